// File: include/snn_params.svh
// ------------------------------
// reset defaults, widths, fifo depth
// and read-only constants of the register bank
// ------------------------------
`ifndef SNN_PARAMS_SVH
`define SNN_PARAMS_SVH

// ------------------------------
// writable register defaults
// ------------------------------
// absolute lif threshold after reset
`define SNN_THRESHOLD_DEFAULT 32'd10000
// timestep count, one frame per step
`define SNN_TIMESTEPS_DEFAULT 8'd10
// shadow ratio code, software side only
`define SNN_RATIO_DEFAULT 8'd4

// ------------------------------
// widths and depths
// ------------------------------
// synthetic adc value width
`define SNN_ADC_BITS 8
// output spike fifo entries
`define SNN_OUT_FIFO_DEPTH 16

// ------------------------------
// constants read back by software
// ------------------------------
`define SNN_NUM_INPUTS 16'd64
`define SNN_NUM_OUTPUTS 8'd10

`endif

// File: hdl/reg_map_pkg.sv
// ------------------------------
// register offset enum, bus word types
// and control register bit positions
// ------------------------------
`default_nettype none

package reg_map_pkg;

  // ------------------------------
  // bus types
  // ------------------------------
  // raw register offset as driven by the master
  typedef logic [7:0] reg_addr_t;
  typedef logic [31:0] word_t;
  // one enable per byte lane
  typedef logic [3:0] wstrb_t;

  // ------------------------------
  // register offsets
  // ------------------------------
  // 0x28, 0x30 and 0x34 stay unmapped and read zero
  typedef enum logic [7:0] {
    REG_THRESHOLD       = 8'h00,
    REG_TIMESTEPS       = 8'h04,
    REG_NUM_INPUTS      = 8'h08,
    REG_NUM_OUTPUTS     = 8'h0C,
    REG_RESET_MODE      = 8'h10,
    REG_CIM_CTRL        = 8'h14,
    REG_STATUS          = 8'h18,
    REG_OUT_DATA        = 8'h1C,
    REG_OUT_COUNT       = 8'h20,
    REG_THRESHOLD_RATIO = 8'h24,
    REG_CIM_TEST        = 8'h2C
  } reg_addr_e;

  // control register fields
  // start and soft reset pulse on write one
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_SRST_BIT  = 1;
  // done is sticky, write one clears
  localparam int CTRL_DONE_BIT  = 7;

endpackage

`default_nettype wire

// File: hdl/snn_status_pkg.sv
// ------------------------------
// datapath status types
// ------------------------------
`default_nettype none

package snn_status_pkg;

  `include "snn_params.svh"

  // current timestep of the running inference
  typedef logic [7:0] timestep_t;

  // output neuron index popped from the spike fifo
  typedef logic [3:0] spike_id_t;

  // entry count, one extra bit so a full fifo fits
  typedef logic [$clog2(`SNN_OUT_FIFO_DEPTH+1)-1:0] fifo_count_t;

  // synthetic adc sample for cim test mode
  typedef logic [`SNN_ADC_BITS-1:0] adc_val_t;

endpackage

`default_nettype wire

// File: hdl/ctrl_reg_file.sv
// ------------------------------
// writable config registers, start and
// soft reset pulses, sticky done flag
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "snn_params.svh"

module ctrl_reg_file
  import reg_map_pkg::*;
  import snn_status_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  // bus request
  input  wire             req_valid,
  input  wire             req_write,
  input  wire reg_addr_t  req_addr,
  input  wire word_t      req_wdata,
  input  wire wstrb_t     req_wstrb,
  // one cycle completion strobe from the snn core
  input  wire             snn_done_pulse,
  // configuration
  output word_t           neuron_threshold,
  output timestep_t       timesteps,
  output logic            reset_mode,
  output logic [7:0]      threshold_ratio,
  output logic            cim_test_mode,
  output adc_val_t        cim_test_data_pos,
  output adc_val_t        cim_test_data_neg,
  // control
  output logic            done_sticky,
  output logic            start_pulse,
  output logic            soft_reset_pulse
);

  logic wr_en;
  logic wr_ctrl;

  // write strobe, addr compared as raw offset
  assign wr_en   = req_valid && req_write;
  assign wr_ctrl = wr_en && (req_addr == REG_CIM_CTRL);

  // ------------------------------
  // configuration registers
  // ------------------------------
  // each field only takes its own byte lanes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      neuron_threshold  <= `SNN_THRESHOLD_DEFAULT;
      timesteps         <= `SNN_TIMESTEPS_DEFAULT;
      threshold_ratio   <= `SNN_RATIO_DEFAULT;
      reset_mode        <= 1'b0;
      cim_test_mode     <= 1'b0;
      cim_test_data_pos <= '0;
      cim_test_data_neg <= '0;
    end else if (wr_en) begin
      case (req_addr)
        REG_THRESHOLD: begin
          // full 32 bit word, byte merge
          for (int b = 0; b < 4; b++) begin
            if (req_wstrb[b]) begin
              neuron_threshold[b*8 +: 8] <= req_wdata[b*8 +: 8];
            end
          end
        end
        REG_TIMESTEPS: begin
          if (req_wstrb[0]) begin
            timesteps <= req_wdata[7:0];
          end
        end
        REG_RESET_MODE: begin
          // 0 soft, 1 hard
          if (req_wstrb[0]) begin
            reset_mode <= req_wdata[0];
          end
        end
        REG_THRESHOLD_RATIO: begin
          // shadow only, threshold itself untouched
          if (req_wstrb[0]) begin
            threshold_ratio <= req_wdata[7:0];
          end
        end
        REG_CIM_TEST: begin
          // mode in byte 0, pos in byte 1, neg in byte 2
          if (req_wstrb[0]) begin
            cim_test_mode <= req_wdata[0];
          end
          if (req_wstrb[1]) begin
            cim_test_data_pos <= req_wdata[15:8];
          end
          if (req_wstrb[2]) begin
            cim_test_data_neg <= req_wdata[23:16];
          end
        end
        default: begin
          // read-only and unmapped offsets, nothing to do
        end
      endcase
    end
  end

  // ------------------------------
  // control register
  // ------------------------------
  // pulses drop every cycle unless rewritten
  // wstrb not looked at here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_pulse      <= 1'b0;
      soft_reset_pulse <= 1'b0;
      done_sticky      <= 1'b0;
    end else begin
      start_pulse      <= wr_ctrl && req_wdata[CTRL_START_BIT];
      soft_reset_pulse <= wr_ctrl && req_wdata[CTRL_SRST_BIT];
      if (snn_done_pulse) begin
        done_sticky <= 1'b1;
      end
      // w1c after the set, so clear wins on a tie
      if (wr_ctrl && req_wdata[CTRL_DONE_BIT]) begin
        done_sticky <= 1'b0;
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  a_start_single: assert property (
    @(posedge clk) disable iff (!rst_n) start_pulse |=> !start_pulse);

  a_srst_single: assert property (
    @(posedge clk) disable iff (!rst_n) soft_reset_pulse |=> !soft_reset_pulse);

  // done only rises after a completion strobe
  a_done_cause: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(done_sticky) |-> $past(snn_done_pulse));

endmodule

`default_nettype wire

// File: hdl/spike_pop_pipe.sv
// ------------------------------
// out fifo read data and delayed pop
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module spike_pop_pipe
  import reg_map_pkg::*;
  import snn_status_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             req_valid,
  input  wire             req_write,
  input  wire reg_addr_t  req_addr,
  // fall-through fifo head
  input  wire             out_fifo_empty,
  input  wire spike_id_t  out_fifo_rdata,
  output word_t           out_data_word,
  output logic            out_fifo_pop
);

  logic rd_out_data;
  logic pop_pending;

  // head zero extended, zero when nothing queued
  assign out_data_word = out_fifo_empty ? '0 :
                         {{($bits(word_t) - $bits(spike_id_t)){1'b0}}, out_fifo_rdata};

  // valid read of the data port with something to pop
  assign rd_out_data = req_valid && !req_write && (req_addr == REG_OUT_DATA) && !out_fifo_empty;

  // ------------------------------
  // pop pipeline
  // ------------------------------
  // read cycle sees the old head, pop lands two edges later
  // back to back reads keep pop high back to back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_pending  <= 1'b0;
      out_fifo_pop <= 1'b0;
    end else begin
      pop_pending  <= rd_out_data;
      out_fifo_pop <= pop_pending;
    end
  end

  // no pop traced back to a read of an empty fifo
  a_pop_not_empty: assert property (
    @(posedge clk) disable iff (!rst_n) out_fifo_pop |-> !$past(out_fifo_empty, 2));

endmodule

`default_nettype wire

// File: hdl/reg_read_mux.sv
// ------------------------------
// read-back decode of the register bank
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "snn_params.svh"

module reg_read_mux
  import reg_map_pkg::*;
  import snn_status_pkg::*;
(
  input  wire reg_addr_t    req_addr,
  // from ctrl_reg_file
  input  wire word_t        neuron_threshold,
  input  wire timestep_t    timesteps,
  input  wire               reset_mode,
  input  wire [7:0]         threshold_ratio,
  input  wire               cim_test_mode,
  input  wire adc_val_t     cim_test_data_pos,
  input  wire adc_val_t     cim_test_data_neg,
  input  wire               done_sticky,
  // from spike_pop_pipe
  input  wire word_t        out_data_word,
  // datapath status
  input  wire               snn_busy,
  input  wire               in_fifo_empty,
  input  wire               in_fifo_full,
  input  wire               out_fifo_empty,
  input  wire               out_fifo_full,
  input  wire timestep_t    timestep_counter,
  input  wire fifo_count_t  out_fifo_count,
  output word_t             rdata
);

  // ------------------------------
  // read decode
  // ------------------------------
  // same cycle as the request, unmapped reads zero
  always_comb begin
    rdata = '0;
    case (req_addr)
      REG_THRESHOLD:       rdata = neuron_threshold;
      REG_TIMESTEPS:       rdata = {24'h0, timesteps};
      REG_NUM_INPUTS:      rdata = {16'h0, `SNN_NUM_INPUTS};
      REG_NUM_OUTPUTS:     rdata = {24'h0, `SNN_NUM_OUTPUTS};
      REG_RESET_MODE:      rdata = {31'h0, reset_mode};
      REG_CIM_CTRL: begin
        // start and soft reset bits always read zero
        rdata[CTRL_DONE_BIT] = done_sticky;
      end
      REG_STATUS: begin
        rdata[0]    = snn_busy;
        rdata[1]    = in_fifo_empty;
        rdata[2]    = in_fifo_full;
        rdata[3]    = out_fifo_empty;
        rdata[4]    = out_fifo_full;
        rdata[15:8] = timestep_counter;
      end
      // already gated against empty
      REG_OUT_DATA:        rdata = out_data_word;
      REG_OUT_COUNT: begin
        rdata = {{($bits(word_t) - $bits(fifo_count_t)){1'b0}}, out_fifo_count};
      end
      REG_THRESHOLD_RATIO: rdata = {24'h0, threshold_ratio};
      REG_CIM_TEST: begin
        // neg in 23:16, pos in 15:8, mode in bit 0
        rdata = {8'h0, cim_test_data_neg, cim_test_data_pos, 7'h0, cim_test_mode};
      end
      default:             rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/reg_bank_top.sv
// ------------------------------
// register bank top, wiring only
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module reg_bank_top
  import reg_map_pkg::*;
  import snn_status_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  // ------------------------------
  // bus
  // ------------------------------
  input  wire               req_valid,
  input  wire               req_write,
  input  wire reg_addr_t    req_addr,
  input  wire word_t        req_wdata,
  input  wire wstrb_t       req_wstrb,
  output word_t             rdata,
  // ------------------------------
  // snn core status
  // ------------------------------
  input  wire               snn_busy,
  input  wire               snn_done_pulse,
  input  wire timestep_t    timestep_counter,
  input  wire               in_fifo_empty,
  input  wire               in_fifo_full,
  input  wire               out_fifo_empty,
  input  wire               out_fifo_full,
  input  wire spike_id_t    out_fifo_rdata,
  input  wire fifo_count_t  out_fifo_count,
  // ------------------------------
  // snn core control
  // ------------------------------
  output word_t             neuron_threshold,
  output timestep_t         timesteps,
  output logic              reset_mode,
  output logic              start_pulse,
  output logic              soft_reset_pulse,
  output logic              cim_test_mode,
  output adc_val_t          cim_test_data_pos,
  output adc_val_t          cim_test_data_neg,
  output logic              out_fifo_pop
);

  // bank internal, read back only
  logic [7:0] threshold_ratio;
  logic       done_sticky;
  word_t      out_data_word;

  ctrl_reg_file u_ctrl_reg_file (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_valid         (req_valid),
    .req_write         (req_write),
    .req_addr          (req_addr),
    .req_wdata         (req_wdata),
    .req_wstrb         (req_wstrb),
    .snn_done_pulse    (snn_done_pulse),
    .neuron_threshold  (neuron_threshold),
    .timesteps         (timesteps),
    .reset_mode        (reset_mode),
    .threshold_ratio   (threshold_ratio),
    .cim_test_mode     (cim_test_mode),
    .cim_test_data_pos (cim_test_data_pos),
    .cim_test_data_neg (cim_test_data_neg),
    .done_sticky       (done_sticky),
    .start_pulse       (start_pulse),
    .soft_reset_pulse  (soft_reset_pulse)
  );

  // pop runs beside the config writes
  spike_pop_pipe u_spike_pop_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_write      (req_write),
    .req_addr       (req_addr),
    .out_fifo_empty (out_fifo_empty),
    .out_fifo_rdata (out_fifo_rdata),
    .out_data_word  (out_data_word),
    .out_fifo_pop   (out_fifo_pop)
  );

  reg_read_mux u_reg_read_mux (
    .req_addr          (req_addr),
    .neuron_threshold  (neuron_threshold),
    .timesteps         (timesteps),
    .reset_mode        (reset_mode),
    .threshold_ratio   (threshold_ratio),
    .cim_test_mode     (cim_test_mode),
    .cim_test_data_pos (cim_test_data_pos),
    .cim_test_data_neg (cim_test_data_neg),
    .done_sticky       (done_sticky),
    .out_data_word     (out_data_word),
    .snn_busy          (snn_busy),
    .in_fifo_empty     (in_fifo_empty),
    .in_fifo_full      (in_fifo_full),
    .out_fifo_empty    (out_fifo_empty),
    .out_fifo_full     (out_fifo_full),
    .timestep_counter  (timestep_counter),
    .out_fifo_count    (out_fifo_count),
    .rdata             (rdata)
  );

endmodule

`default_nettype wire

// File: sim/tb_spike_fifo.sv
// ------------------------------
// fall-through spike fifo model
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "snn_params.svh"

module tb_spike_fifo
  import snn_status_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  // filled by the testbench
  input  wire              push,
  input  wire spike_id_t   push_data,
  // drained by the DUT
  input  wire              pop,
  output spike_id_t        head,
  output logic             empty,
  output logic             full,
  output fifo_count_t      count
);

  localparam int DEPTH = `SNN_OUT_FIFO_DEPTH;

  spike_id_t                mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic                     do_push;
  logic                     do_pop;

  // push dropped when full, pop ignored when empty
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // head visible without a read strobe
  assign head  = mem[rd_ptr];
  assign empty = (count == 0);
  assign full  = (count == DEPTH);

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap at depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + do_push;
      rd_ptr <= rd_ptr + do_pop;
      count  <= count + do_push - do_pop;
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_reg_bank.sv
// ------------------------------
// register bank testbench, random bus
// traffic against a register model
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "snn_params.svh"

module tb_reg_bank
  import reg_map_pkg::*;
  import snn_status_pkg::*;
();

  localparam int     CLK_PERIOD  = 40;
  localparam int     DEPTH       = `SNN_OUT_FIFO_DEPTH;
  localparam int     NUM_PAIRS   = 100;
  localparam int     NUM_TXN     = 600;
  // directed cycles plus reset, rounded up
  localparam int     TOTAL_TXN   = 2 * NUM_PAIRS + NUM_TXN + 120;
  localparam longint WATCHDOG_NS = longint'(TOTAL_TXN) * 4 * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_write;
  reg_addr_t   req_addr;
  word_t       req_wdata;
  wstrb_t      req_wstrb;
  logic        snn_busy;
  logic        snn_done_pulse;
  logic        in_fifo_empty;
  logic        in_fifo_full;
  timestep_t   timestep_counter;
  logic        out_fifo_empty;
  logic        out_fifo_full;
  spike_id_t   fifo_head;
  fifo_count_t out_fifo_count;
  word_t       rdata;
  word_t       neuron_threshold;
  timestep_t   timesteps;
  logic        reset_mode;
  logic        start_pulse;
  logic        soft_reset_pulse;
  logic        cim_test_mode;
  adc_val_t    cim_test_data_pos;
  adc_val_t    cim_test_data_neg;
  logic        out_fifo_pop;
  logic        push_en;
  spike_id_t   push_id;
  integer      seed;

  // ------------------------------
  // register model
  // ------------------------------
  word_t       m_threshold;
  timestep_t   m_timesteps;
  logic        m_reset_mode;
  logic [7:0]  m_ratio;
  logic        m_cim_mode;
  adc_val_t    m_pos;
  adc_val_t    m_neg;
  logic        m_done;
  logic        m_start;
  logic        m_srst;
  logic        m_pend;
  logic        m_pop;
  spike_id_t   m_q [$];

  // mapped, read-only and unmapped offsets
  reg_addr_t addr_pool [14] = '{REG_THRESHOLD, REG_TIMESTEPS, REG_NUM_INPUTS,
    REG_NUM_OUTPUTS, REG_RESET_MODE, REG_CIM_CTRL, REG_STATUS, REG_OUT_DATA,
    REG_OUT_COUNT, REG_THRESHOLD_RATIO, REG_CIM_TEST, 8'h28, 8'h30, 8'h34};

  reg_bank_top UUT (
    .clk (clk), .rst_n (rst_n),
    .req_valid (req_valid), .req_write (req_write), .req_addr (req_addr),
    .req_wdata (req_wdata), .req_wstrb (req_wstrb), .rdata (rdata),
    .snn_busy (snn_busy), .snn_done_pulse (snn_done_pulse),
    .timestep_counter (timestep_counter),
    .in_fifo_empty (in_fifo_empty), .in_fifo_full (in_fifo_full),
    .out_fifo_empty (out_fifo_empty), .out_fifo_full (out_fifo_full),
    .out_fifo_rdata (fifo_head), .out_fifo_count (out_fifo_count),
    .neuron_threshold (neuron_threshold), .timesteps (timesteps),
    .reset_mode (reset_mode), .start_pulse (start_pulse),
    .soft_reset_pulse (soft_reset_pulse), .cim_test_mode (cim_test_mode),
    .cim_test_data_pos (cim_test_data_pos), .cim_test_data_neg (cim_test_data_neg),
    .out_fifo_pop (out_fifo_pop)
  );

  tb_spike_fifo u_fifo (
    .clk (clk), .rst_n (rst_n), .push (push_en), .push_data (push_id),
    .pop (out_fifo_pop), .head (fifo_head), .empty (out_fifo_empty),
    .full (out_fifo_full), .count (out_fifo_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("Checks failed");
    $fatal(1, "run stopped by watchdog");
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_pulse(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("Mismatch %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_spike(input string name, input spike_id_t exp, input spike_id_t act);
    if (act !== exp) begin
      stop_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  // expected read word for the model state of this cycle
  function automatic word_t expect_rdata(input reg_addr_t a);
    word_t r;
    r = '0;
    case (a)
      REG_THRESHOLD:       r = m_threshold;
      REG_TIMESTEPS:       r[7:0] = m_timesteps;
      REG_NUM_INPUTS:      r[15:0] = `SNN_NUM_INPUTS;
      REG_NUM_OUTPUTS:     r[7:0] = `SNN_NUM_OUTPUTS;
      REG_RESET_MODE:      r[0] = m_reset_mode;
      REG_CIM_CTRL:        r[CTRL_DONE_BIT] = m_done;
      REG_STATUS: begin
        r[0]    = snn_busy;
        r[1]    = in_fifo_empty;
        r[2]    = in_fifo_full;
        r[3]    = (m_q.size() == 0);
        r[4]    = (m_q.size() == DEPTH);
        r[15:8] = timestep_counter;
      end
      REG_OUT_DATA: begin
        if (m_q.size() != 0) begin
          r[3:0] = m_q[0];
        end
      end
      REG_OUT_COUNT:       r = word_t'(m_q.size());
      REG_THRESHOLD_RATIO: r[7:0] = m_ratio;
      REG_CIM_TEST: begin
        r[0]     = m_cim_mode;
        r[15:8]  = m_pos;
        r[23:16] = m_neg;
      end
      default:             r = '0;
    endcase
    return r;
  endfunction

  // model state after the edge that ends the cycle
  task automatic model_edge(input logic v, input logic w, input reg_addr_t a,
                            input word_t d, input wstrb_t s, input logic done);
    logic      wr;
    logic      wr_ctrl;
    logic      pend_next;
    logic      push_ok;
    spike_id_t dropped;
    wr        = v && w;
    wr_ctrl   = wr && (a == REG_CIM_CTRL);
    pend_next = v && !w && (a == REG_OUT_DATA) && (m_q.size() != 0);
    push_ok   = push_en && (m_q.size() < DEPTH);
    if (m_pop && m_q.size() != 0) begin
      dropped = m_q.pop_front();
    end
    if (push_ok) begin
      m_q.push_back(push_id);
    end
    m_pop   = m_pend;
    m_pend  = pend_next;
    m_start = wr_ctrl && d[CTRL_START_BIT];
    m_srst  = wr_ctrl && d[CTRL_SRST_BIT];
    if (done) begin
      m_done = 1'b1;
    end
    // clear beats set
    if (wr_ctrl && d[CTRL_DONE_BIT]) begin
      m_done = 1'b0;
    end
    if (wr) begin
      case (a)
        REG_THRESHOLD: begin
          for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
              m_threshold[b*8 +: 8] = d[b*8 +: 8];
            end
          end
        end
        REG_TIMESTEPS:       if (s[0]) m_timesteps = d[7:0];
        REG_RESET_MODE:      if (s[0]) m_reset_mode = d[0];
        REG_THRESHOLD_RATIO: if (s[0]) m_ratio = d[7:0];
        REG_CIM_TEST: begin
          if (s[0]) m_cim_mode = d[0];
          if (s[1]) m_pos = d[15:8];
          if (s[2]) m_neg = d[23:16];
        end
        default: begin
        end
      endcase
    end
  endtask

  // ------------------------------
  // one bus cycle, checked at negedge
  // ------------------------------
  task automatic bus_cycle(input string name, input logic v, input logic w,
                           input reg_addr_t a, input word_t d, input wstrb_t s,
                           input logic done);
    req_valid      = v;
    req_write      = w;
    req_addr       = a;
    req_wdata      = d;
    req_wstrb      = s;
    snn_done_pulse = done;
    @(negedge clk);
    check_word({name, " threshold"}, m_threshold, neuron_threshold);
    check_word({name, " timesteps"}, {24'h0, m_timesteps}, {24'h0, timesteps});
    check_word({name, " cim data"}, {16'h0, m_neg, m_pos},
               {16'h0, cim_test_data_neg, cim_test_data_pos});
    check_pulse({name, " reset_mode"}, m_reset_mode, reset_mode);
    check_pulse({name, " cim_test_mode"}, m_cim_mode, cim_test_mode);
    check_pulse({name, " start_pulse"}, m_start, start_pulse);
    check_pulse({name, " soft_reset_pulse"}, m_srst, soft_reset_pulse);
    check_pulse({name, " out_fifo_pop"}, m_pop, out_fifo_pop);
    if (v && !w) begin
      check_word({name, " rdata"}, expect_rdata(a), rdata);
      if (a == REG_OUT_DATA && m_q.size() != 0) begin
        check_spike({name, " out data id"}, m_q[0], rdata[3:0]);
      end
    end
    model_edge(v, w, a, d, s, done);
    @(posedge clk);
    #2;
    push_en        = 1'b0;
    snn_done_pulse = 1'b0;
  endtask

  task automatic write_reg(input string name, input reg_addr_t a, input word_t d,
                           input wstrb_t s);
    bus_cycle(name, 1'b1, 1'b1, a, d, s, 1'b0);
  endtask

  task automatic read_reg(input string name, input reg_addr_t a);
    bus_cycle(name, 1'b1, 1'b0, a, '0, '0, 1'b0);
  endtask

  task automatic idle_cycle(input string name, input logic done);
    bus_cycle(name, 1'b0, 1'b0, REG_THRESHOLD, '0, '0, done);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    logic      v;
    logic      w;
    logic      done;
    reg_addr_t a;
    word_t     d;
    wstrb_t    s;
    seed             = 32'h38f4_14f2;
    rst_n            = 1'b0;
    req_valid        = 1'b0;
    req_write        = 1'b0;
    req_addr         = '0;
    req_wdata        = '0;
    req_wstrb        = '0;
    snn_busy         = 1'b0;
    snn_done_pulse   = 1'b0;
    in_fifo_empty    = 1'b0;
    in_fifo_full     = 1'b0;
    timestep_counter = '0;
    push_en          = 1'b0;
    push_id          = '0;
    m_threshold      = `SNN_THRESHOLD_DEFAULT;
    m_timesteps      = `SNN_TIMESTEPS_DEFAULT;
    m_ratio          = `SNN_RATIO_DEFAULT;
    m_reset_mode     = 1'b0;
    m_cim_mode       = 1'b0;
    m_pos            = '0;
    m_neg            = '0;
    m_done           = 1'b0;
    m_start          = 1'b0;
    m_srst           = 1'b0;
    m_pend           = 1'b0;
    m_pop            = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // defaults right after reset
    for (int i = 0; i < 14; i++) begin
      read_reg("reset_defaults", addr_pool[i]);
    end

    // write then read back, random lanes
    for (int i = 0; i < NUM_PAIRS; i++) begin
      a = addr_pool[{$random(seed)} % 14];
      if (a == REG_CIM_CTRL) begin
        a = REG_THRESHOLD;
      end
      d = $random(seed);
      s = $random(seed);
      write_reg("write_readback", a, d, s);
      read_reg("write_readback", a);
    end

    // start and soft reset strobes
    write_reg("ctrl_pulse", REG_CIM_CTRL, 32'h3, 4'h0);
    idle_cycle("ctrl_pulse", 1'b0);
    write_reg("ctrl_pulse", REG_CIM_CTRL, 32'h1, 4'hF);
    write_reg("ctrl_pulse", REG_CIM_CTRL, 32'h2, 4'hF);
    idle_cycle("ctrl_pulse", 1'b0);
    idle_cycle("ctrl_pulse", 1'b0);

    // sticky done, w1c, clear against set
    idle_cycle("done_w1c", 1'b1);
    read_reg("done_w1c", REG_CIM_CTRL);
    write_reg("done_w1c", REG_CIM_CTRL, 32'h80, 4'h1);
    read_reg("done_w1c", REG_CIM_CTRL);
    idle_cycle("done_w1c", 1'b1);
    bus_cycle("done_tie", 1'b1, 1'b1, REG_CIM_CTRL, 32'h80, 4'h0, 1'b1);
    read_reg("done_tie", REG_CIM_CTRL);

    // status and constants
    snn_busy         = 1'b1;
    in_fifo_full     = 1'b1;
    timestep_counter = 8'hA5;
    read_reg("status_const", REG_STATUS);
    read_reg("status_const", REG_NUM_INPUTS);
    read_reg("status_const", REG_NUM_OUTPUTS);
    read_reg("status_const", REG_OUT_COUNT);

    // fill six spikes, drain with back to back reads
    for (int i = 0; i < 6; i++) begin
      push_en = 1'b1;
      push_id = $random(seed);
      idle_cycle("out_data_drain", 1'b0);
    end
    read_reg("out_data_drain", REG_OUT_COUNT);
    repeat (6) read_reg("out_data_drain", REG_OUT_DATA);
    repeat (3) idle_cycle("out_data_drain", 1'b0);
    read_reg("out_data_drain", REG_OUT_COUNT);
    read_reg("out_data_drain", REG_OUT_DATA);

    // mixed random traffic
    for (int i = 0; i < NUM_TXN; i++) begin
      snn_busy         = $random(seed);
      in_fifo_empty    = $random(seed);
      in_fifo_full     = $random(seed);
      timestep_counter = $random(seed);
      push_en          = (({$random(seed)} % 3) == 0) && (m_q.size() < DEPTH);
      push_id          = $random(seed);
      v    = ({$random(seed)} % 4) != 0;
      w    = $random(seed);
      a    = addr_pool[{$random(seed)} % 14];
      d    = $random(seed);
      // no strobe bit while that strobe is still high
      if (m_start) begin
        d[CTRL_START_BIT] = 1'b0;
      end
      if (m_srst) begin
        d[CTRL_SRST_BIT] = 1'b0;
      end
      s    = $random(seed);
      done = ({$random(seed)} % 8) == 0;
      bus_cycle("random_access", v, w, a, d, s, done);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hdl/reg_map_pkg.sv
hdl/snn_status_pkg.sv
hdl/ctrl_reg_file.sv
hdl/spike_pop_pipe.sv
hdl/reg_read_mux.sv
hdl/reg_bank_top.sv
sim/tb_spike_fifo.sv
sim/tb_reg_bank.sv

// File: Bender.yml
package:
  name: snn_reg_bank

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/reg_map_pkg.sv
      - hdl/snn_status_pkg.sv
      - hdl/ctrl_reg_file.sv
      - hdl/spike_pop_pipe.sv
      - hdl/reg_read_mux.sv
      - hdl/reg_bank_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_spike_fifo.sv
      - sim/tb_reg_bank.sv
